//--- all.f
+incdir+src
src/icache_pkg.sv
src/icache_data_ram.sv
src/icache_tag_ram.sv
src/icache_ctrl.sv
src/icache.sv
verif/icache_tb.sv

//--- Makefile
# Verilator lint and simulation for the instruction cache

VERILATOR  ?= verilator
TOP        := icache_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/icache_tb.sv
// Instruction cache testbench: clock, reset, memory model, reference functions, checks, watchdog

`default_nettype none

`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int NUM_RANDOM      = 2000;
    localparam int WATCHDOG_CYCLES = 600 + NUM_RANDOM * 20;
    localparam int SWEEP_CYCLES    = 514;   // Tag sweep plus two settle cycles

    logic                        clk_i = 1'b0;
    logic                        rst_i;
    icache_addr_t                fetch_addr;
    logic                        fetch_wait_o;
    logic [`ICACHE_WORD_W-1:0]   fetch_data_o;
    mem_req_t                    mem_req_o;
    mem_rsp_t                    mem_rsp = '0;

    integer                      seed = 32'h8fbb;
    tag_entry_t                  shadow [`ICACHE_LINES];     // Expected tag RAM contents
    mem_req_t                    held_req;
    logic                        req_pending;
    int                          wait_left;
    int                          fill_cnt;

    icache dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fetch_addr_i (fetch_addr),
        .fetch_wait_o (fetch_wait_o),
        .fetch_data_o (fetch_data_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp)
    );

    always #5 clk_i = ~clk_i;

    // ==================================================
    // Reference model
    // ==================================================

    function automatic logic [`ICACHE_WORD_W-1:0] mem_word(
        input logic [`ICACHE_MEM_ADDR_W-1:0] waddr
    );
        return (32'(waddr) * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic line_resident(input logic [`ICACHE_TAG_W-1:0] tag,
                                           input logic [`ICACHE_INDEX_W-1:0] index);
        return shadow[index].valid && (shadow[index].tag == tag);
    endfunction

    // Line A first, then the next line with the same tag
    function automatic mem_req_t expected_req(input icache_addr_t addr);
        mem_req_t                   req;
        logic [`ICACHE_INDEX_W-1:0] index_b;
        index_b   = addr.index + `ICACHE_INDEX_W'(1);
        req.valid = 1'b1;
        if (line_resident(addr.tag, addr.index)) begin
            req.addr = {addr.tag, index_b};
        end else begin
            req.addr = {addr.tag, addr.index};
        end
        return req;
    endfunction

    function automatic int predict_fills(input icache_addr_t addr);
        logic [`ICACHE_INDEX_W-1:0] index_b;
        int                         fills;
        index_b = addr.index + `ICACHE_INDEX_W'(1);
        fills   = 0;
        if (!line_resident(addr.tag, addr.index)) fills++;
        if (!line_resident(addr.tag, index_b)) fills++;
        return fills;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input logic [`ICACHE_WORD_W-1:0] actual,
                              input logic [`ICACHE_WORD_W-1:0] expected,
                              input icache_addr_t addr);
        if (actual !== expected) begin
            abort_run($sformatf("error: %0t: fetch data for address %h is %h, expected %h",
                                $time, addr, actual, expected));
        end
    endtask

    task automatic check_req(input mem_req_t actual, input mem_req_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("error: %0t: memory request %b/%h, expected %b/%h",
                                $time, actual.valid, actual.addr, expected.valid, expected.addr));
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("error: %0t: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    // ==================================================
    // Backing memory
    // ==================================================

    always @(posedge clk_i) begin
        if (rst_i) begin
            mem_rsp     <= '0;
            req_pending = 1'b0;
            wait_left   = 0;
            fill_cnt    = 0;
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                shadow[i] = '0;
            end
        end else if (mem_rsp.ready) begin
            // Fill completes at this edge
            check_req(mem_req_o, held_req);
            shadow[held_req.addr[`ICACHE_INDEX_W-1:0]] =
                {1'b1, held_req.addr[`ICACHE_MEM_ADDR_W-1:`ICACHE_INDEX_W]};
            fill_cnt++;
            req_pending = 1'b0;
            mem_rsp     <= '0;
        end else if (mem_req_o.valid) begin
            if (!req_pending) begin
                check_req(mem_req_o, expected_req(fetch_addr));
                held_req    = mem_req_o;
                req_pending = 1'b1;
                wait_left   = $unsigned($random(seed)) % 32'd6;
            end else begin
                check_req(mem_req_o, held_req);     // Address held while waiting
            end
            if (wait_left == 0) begin
                mem_rsp <= {1'b1, mem_word(held_req.addr)};
            end else begin
                wait_left--;
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    // Called right after a rising edge, returns at the edge that sees the fetch done
    task automatic run_fetch(input icache_addr_t addr);
        int exp_fills;
        int base_fills;
        exp_fills  = predict_fills(addr);
        base_fills = fill_cnt;
        fetch_addr <= addr;
        @(posedge clk_i);
        check_flag("fetch_wait_o", fetch_wait_o, exp_fills != 0);
        check_flag("mem_req_o.valid", mem_req_o.valid, exp_fills != 0);
        while (fetch_wait_o) begin
            @(posedge clk_i);
        end
        if (fill_cnt - base_fills != exp_fills) begin
            abort_run($sformatf("error: %0t: fetch %h took %0d fills, expected %0d",
                                $time, addr, fill_cnt - base_fills, exp_fills));
        end
        check_word(fetch_data_o, mem_word({addr.tag, addr.index}), addr);
    endtask

    initial begin
        icache_addr_t addr;
        logic [31:0]  rnd;

        rst_i      = 1'b1;
        fetch_addr = '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;

        // Stalled and silent through the sweep
        repeat (SWEEP_CYCLES) begin
            @(posedge clk_i);
            check_flag("fetch_wait_o", fetch_wait_o, 1'b1);
            check_req(mem_req_o, '0);
        end

        // Cold fetches
        run_fetch('0);
        run_fetch({8'h3c, 9'h0a5, 1'b0});

        // Resident words, both halves
        run_fetch({8'h3c, 9'h0a5, 1'b1});
        run_fetch({8'h3c, 9'h0a5, 1'b0});
        run_fetch({8'h3c, 9'h0a6, 1'b0});   // Only line B missing

        // Same index, other tag
        repeat (3) begin
            run_fetch({8'h71, 9'h0a5, 1'b0});
            run_fetch({8'h3c, 9'h0a5, 1'b1});
        end

        // Line B wraps to index 0
        run_fetch({8'h22, 9'h1ff, 1'b1});
        run_fetch({8'h22, 9'h1ff, 1'b0});
        run_fetch({8'h22, 9'h000, 1'b0});   // Index 0 now hits as line A

        // Random fetches over a few tags so that hits and evictions mix
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd        = $random(seed);
            addr.tag   = {6'd0, rnd[1:0]};
            addr.index = rnd[10:2];
            addr.half  = rnd[11];
            run_fetch(addr);
        end

        $display("TEST PASS");
        $finish;
    end

    // ==================================================
    // Watchdog
    // ==================================================

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        abort_run("simulation timed out before all fetches completed");
    end

endmodule

`default_nettype wire

//--- src/icache.sv
// Instruction cache top level: controller, tag RAM and data RAM

`default_nettype none

`include "icache_defs.svh"

module icache
    import icache_pkg::*;
(
    input  wire                             clk_i,
    input  wire                             rst_i,

    input  wire  icache_addr_t              fetch_addr_i,
    output logic                            fetch_wait_o,
    output logic [`ICACHE_WORD_W-1:0]       fetch_data_o,

    output mem_req_t                        mem_req_o,
    input  wire  mem_rsp_t                  mem_rsp_i
);

    tag_entry_t                  entry_a;
    tag_entry_t                  entry_b;
    logic [`ICACHE_INDEX_W-1:0]  lookup_b_index;
    line_write_t                 line_write;

    icache_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .fetch_addr_i     (fetch_addr_i),
        .entry_a_i        (entry_a),
        .entry_b_i        (entry_b),
        .mem_rsp_i        (mem_rsp_i),
        .lookup_b_index_o (lookup_b_index),
        .mem_req_o        (mem_req_o),
        .fetch_wait_o     (fetch_wait_o),
        .line_write_o     (line_write)
    );

    // Port A follows the fetch index, port B the next line
    icache_tag_ram #(
        .DEPTH (`ICACHE_LINES)
    ) u_tag_ram (
        .clk_i     (clk_i),
        .we_i      (line_write.en),
        .waddr_i   (line_write.index),
        .wentry_i  (line_write.entry),
        .raddr_a_i (fetch_addr_i.index),
        .entry_a_o (entry_a),
        .raddr_b_i (lookup_b_index),
        .entry_b_o (entry_b)
    );

    icache_data_ram #(
        .DATA_WIDTH (`ICACHE_WORD_W),
        .DEPTH      (`ICACHE_LINES)
    ) u_data_ram (
        .clk_i   (clk_i),
        .we_i    (line_write.en),
        .waddr_i (line_write.index),
        .wdata_i (line_write.data),
        .raddr_i (fetch_addr_i.index),
        .rdata_o (fetch_data_o)     // Word holding the fetch address
    );

endmodule

`default_nettype wire

//--- src/icache_ctrl.sv
// Instruction cache controller: init sweep, two-line hit check, miss request and line write

`default_nettype none

`include "icache_defs.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  wire                             clk_i,
    input  wire                             rst_i,

    input  wire  icache_addr_t              fetch_addr_i,
    input  wire  tag_entry_t                entry_a_i,
    input  wire  tag_entry_t                entry_b_i,
    input  wire  mem_rsp_t                  mem_rsp_i,

    output logic [`ICACHE_INDEX_W-1:0]      lookup_b_index_o,
    output mem_req_t                        mem_req_o,
    output logic                            fetch_wait_o,
    output line_write_t                     line_write_o
);

    typedef enum logic [1:0] {
        ST_INIT,
        ST_SETTLE1,
        ST_SETTLE2,
        ST_READY
    } state_t;

    localparam logic [`ICACHE_INDEX_W-1:0] LAST_INDEX = `ICACHE_INDEX_W'(`ICACHE_LINES - 1);

    state_t                      state_q;
    state_t                      state_d;
    logic [`ICACHE_INDEX_W-1:0]  sweep_cnt_q;
    logic [`ICACHE_INDEX_W-1:0]  index_b;
    logic [`ICACHE_INDEX_W-1:0]  req_index;
    logic                        hit_a;
    logic                        hit_b;
    logic                        fetch_miss;

    // ==================================================
    // Lookup and hit detection
    // ==================================================

    assign index_b          = fetch_addr_i.index + `ICACHE_INDEX_W'(1);   // Wraps 511 to 0
    assign lookup_b_index_o = index_b;

    assign hit_a = entry_a_i.valid && (entry_a_i.tag == fetch_addr_i.tag);
    assign hit_b = entry_b_i.valid && (entry_b_i.tag == fetch_addr_i.tag);

    assign fetch_miss = !(hit_a && hit_b);
    assign req_index  = hit_a ? index_b : fetch_addr_i.index;    // Fill A before B

    // ==================================================
    // State and sweep counter
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sweep_cnt_q <= '0;
        end else if (state_q == ST_INIT) begin
            sweep_cnt_q <= sweep_cnt_q + `ICACHE_INDEX_W'(1);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: begin
                if (sweep_cnt_q == LAST_INDEX) begin
                    state_d = ST_SETTLE1;
                end
            end
            ST_SETTLE1: state_d = ST_SETTLE2;
            ST_SETTLE2: state_d = ST_READY;
            ST_READY:   state_d = ST_READY;
            default:    state_d = ST_INIT;
        endcase
    end

    // ==================================================
    // Outputs
    // ==================================================

    always_comb begin
        mem_req_o    = '0;
        fetch_wait_o = 1'b1;
        line_write_o = '0;

        case (state_q)
            ST_INIT: begin
                // Invalid entry at the sweep index, data is don't care
                line_write_o.en    = 1'b1;
                line_write_o.index = sweep_cnt_q;
            end
            ST_READY: begin
                fetch_wait_o    = fetch_miss;
                mem_req_o.valid = fetch_miss;
                mem_req_o.addr  = {fetch_addr_i.tag, req_index};

                line_write_o.en          = fetch_miss && mem_rsp_i.ready;
                line_write_o.index       = req_index;
                line_write_o.entry.valid = 1'b1;
                line_write_o.entry.tag   = fetch_addr_i.tag;
                line_write_o.data        = mem_rsp_i.rdata;
            end
            default: begin
                // Settle cycles keep the fetch stalled with no write
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/icache_tag_ram.sv
// Flip-flop tag RAM with one write port and two combinational read ports

`default_nettype none

module icache_tag_ram
    import icache_pkg::*;
#(
    parameter int DEPTH = 512
) (
    input  wire                         clk_i,

    input  wire                         we_i,
    input  wire  [$clog2(DEPTH)-1:0]    waddr_i,
    input  wire  tag_entry_t            wentry_i,

    input  wire  [$clog2(DEPTH)-1:0]    raddr_a_i,
    output tag_entry_t                  entry_a_o,

    input  wire  [$clog2(DEPTH)-1:0]    raddr_b_i,
    output tag_entry_t                  entry_b_o
);

    // Valid bit and tag per line, cleared by the init sweep
    tag_entry_t mem_q [DEPTH];

    // ==================================================
    // Write port
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wentry_i;
        end
    end

    // ==================================================
    // Read ports
    // ==================================================

    // Port A looks up the word holding the fetch address,
    // port B the word after it, both in the same cycle
    assign entry_a_o = mem_q[raddr_a_i];
    assign entry_b_o = mem_q[raddr_b_i];

endmodule

`default_nettype wire

//--- src/icache_data_ram.sv
// Flip-flop word RAM with one synchronous write port and one combinational read port

`default_nettype none

module icache_data_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 512
) (
    input  wire                         clk_i,

    input  wire                         we_i,
    input  wire  [$clog2(DEPTH)-1:0]    waddr_i,
    input  wire  [DATA_WIDTH-1:0]       wdata_i,

    input  wire  [$clog2(DEPTH)-1:0]    raddr_i,
    output logic [DATA_WIDTH-1:0]       rdata_o
);

    // Contents are guarded by the valid bits in the tag RAM
    logic [DATA_WIDTH-1:0] mem_q [DEPTH];

    // ==================================================
    // Write port
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // ==================================================
    // Read port
    // ==================================================

    assign rdata_o = mem_q[raddr_i];    // Same-cycle read

endmodule

`default_nettype wire

//--- src/icache_pkg.sv
// Instruction cache types: fetch address, tag entry, memory bus and line write

`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    // ==================================================
    // Fetch side
    // ==================================================

    // Halfword fetch address, bits 18 down to 1
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_INDEX_W-1:0] index;
        logic                       half;   // Upper halfword of the word
    } icache_addr_t;

    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // ==================================================
    // Memory side
    // ==================================================

    typedef struct packed {
        logic                          valid;
        logic [`ICACHE_MEM_ADDR_W-1:0] addr;    // Word address
    } mem_req_t;

    typedef struct packed {
        logic                      ready;
        logic [`ICACHE_WORD_W-1:0] rdata;   // Valid in the ready cycle
    } mem_rsp_t;

    // One write that goes to both the tag and the data RAM
    typedef struct packed {
        logic                       en;
        logic [`ICACHE_INDEX_W-1:0] index;
        tag_entry_t                 entry;
        logic [`ICACHE_WORD_W-1:0]  data;
    } line_write_t;

endpackage

`default_nettype wire

//--- src/icache_defs.svh
// Width and size macros for the instruction cache

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ==================================================
// Line geometry
// ==================================================

`define ICACHE_LINES       512  // Direct-mapped, one word per line
`define ICACHE_INDEX_W     9    // log2 of line count
`define ICACHE_TAG_W       8    // Fetch address bits 18:11

// ==================================================
// Data and memory side
// ==================================================

`define ICACHE_WORD_W      32   // Instruction word
`define ICACHE_MEM_ADDR_W  17   // Tag plus index, word address

`endif
